//--- include/disp_params.svh
`ifndef DISP_PARAMS_SVH
`define DISP_PARAMS_SVH

// Width of the binary register value shown on the display.
`define VALUE_WIDTH 16

// Scanned digit positions, lower anodes only.
`define DIGIT_COUNT 4

// Clock cycles per digit slot on the board.
`define SCAN_DIV_DEFAULT 50000

`endif

//--- hdl/dispTypesPkg.sv
`include "disp_params.svh"

package dispTypesPkg;

    // Raw register value as it arrives from the writer.
    typedef logic [`VALUE_WIDTH-1:0] binValue_t;

    // One decimal digit.
    typedef logic [3:0] bcdDigit_t;

    // Index 0 is the ones digit.
    typedef bcdDigit_t [`DIGIT_COUNT-1:0] bcdWord_t;

endpackage

//--- hdl/segPatternPkg.sv
package segPatternPkg;

    // Active low, bit 6 is segment g and bit 0 is segment a.
    typedef logic [6:0] segPattern_t;

    // Active low, one bit per anode.
    typedef logic [7:0] anodeMask_t;

    // Common-anode patterns for the digits 0 to 9.
    localparam segPattern_t SEG_DIGIT [0:9] = '{
        7'b1000000, // 0.
        7'b1111001, // 1.
        7'b0100100, // 2.
        7'b0110000, // 3.
        7'b0011001, // 4.
        7'b0010010, // 5.
        7'b0000010, // 6.
        7'b1111000, // 7.
        7'b0000000, // 8.
        7'b0010000  // 9.
    };

    // Only segment d lit, used for overflow and bad digits.
    localparam segPattern_t SEG_BROKEN = 7'b1110111;

endpackage

//--- hdl/bcdIf.sv
`timescale 1ns/1ns

interface bcdIf;

    logic valid;
    logic ready;
    dispTypesPkg::bcdWord_t digits;
    logic overflow; // Value was above 9999.

    // Converter side.
    modport source (
        output valid,
        output digits,
        output overflow,
        input  ready
    );

    // Display side.
    modport sink (
        input  valid,
        input  digits,
        input  overflow,
        output ready
    );

endinterface

//--- hdl/valueSkid.sv
`timescale 1ns/1ns

module valueSkid (
    input  logic                   clock,
    input  logic                   rst,
    input  dispTypesPkg::binValue_t inValue,
    input  logic                   inValid,
    output logic                   inReady,
    output dispTypesPkg::binValue_t outValue,
    output logic                   outValid,
    input  logic                   outReady
);

    dispTypesPkg::binValue_t skidValue;
    logic                    skidValid;
    logic                    inFire;
    logic                    outFire;
    logic                    headFree;

    assign inFire   = inValid && inReady;
    assign outFire  = outValid && outReady;
    assign headFree = outFire || !outValid; // Head can take a new entry.

    // Skid entry full means both entries are full.
    assign inReady = !skidValid;

    always_ff @(posedge clock) begin
        if (rst) begin
            outValid  <= 1'b0;
            skidValid <= 1'b0;
        end else if (headFree) begin
            if (skidValid) begin
                outValid  <= 1'b1; // Older entry moves up first.
                skidValid <= 1'b0;
            end else begin
                outValid <= inFire;
            end
        end else if (inFire) begin
            skidValid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (headFree) begin
            outValue <= skidValid ? skidValue : inValue;
        end
        if (inFire && !headFree) begin
            skidValue <= inValue;
        end
    end

endmodule

//--- hdl/binToBcd.sv
`timescale 1ns/1ns
`include "disp_params.svh"

module binToBcd (
    input  logic                   clock,
    input  logic                   rst,
    input  dispTypesPkg::binValue_t inValue,
    input  logic                   inValid,
    output logic                   inReady,
    bcdIf.source                   bcdOut
);

    // One spare digit catches values above 9999.
    localparam int BCD_DIGITS = `DIGIT_COUNT + 1;
    localparam int BCD_BITS   = 4 * BCD_DIGITS;
    localparam int CNT_BITS   = $clog2(`VALUE_WIDTH);
    localparam logic [CNT_BITS-1:0] BIT_LAST = CNT_BITS'(`VALUE_WIDTH - 1);

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        DONE
    } state_t;

    state_t                  state;
    dispTypesPkg::binValue_t binReg;
    logic [BCD_BITS-1:0]     bcdReg;
    logic [BCD_BITS-1:0]     bcdAdj;
    logic [CNT_BITS-1:0]     bitCount;

    // Correct every digit of five or more before the next shift.
    function automatic logic [BCD_BITS-1:0] addThree(input logic [BCD_BITS-1:0] bcd);
        logic [BCD_BITS-1:0] result;
        result = bcd;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            if (result[4*i +: 4] >= 4'd5) begin
                result[4*i +: 4] = result[4*i +: 4] + 4'd3;
            end
        end
        return result;
    endfunction

    assign bcdAdj = addThree(bcdReg);

    assign inReady = (state == IDLE);
    assign bcdOut.valid = (state == DONE);
    assign bcdOut.digits = dispTypesPkg::bcdWord_t'(bcdReg[4*`DIGIT_COUNT-1:0]);
    assign bcdOut.overflow = |bcdReg[BCD_BITS-1:4*`DIGIT_COUNT]; // Fifth digit nonzero.

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (inValid) begin
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (bitCount == BIT_LAST) begin
                        state <= DONE; // All bits consumed.
                    end
                end
                DONE: begin
                    if (bcdOut.ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && inValid) begin
            binReg   <= inValue;
            bcdReg   <= '0;
            bitCount <= '0;
        end else if (state == SHIFT) begin
            bcdReg   <= {bcdAdj[BCD_BITS-2:0], binReg[`VALUE_WIDTH-1]}; // MSB first.
            binReg   <= {binReg[`VALUE_WIDTH-2:0], 1'b0};
            bitCount <= bitCount + 1'b1;
        end
    end

endmodule

//--- hdl/segmentScanner.sv
`timescale 1ns/1ns
`include "disp_params.svh"

module segmentScanner #(
    parameter int scanDivider = `SCAN_DIV_DEFAULT
) (
    input  logic                      clock,
    input  logic                      rst,
    bcdIf.sink                        bcdIn,
    output segPatternPkg::anodeMask_t an,
    output segPatternPkg::segPattern_t seg
);

    localparam int DIV_BITS  = (scanDivider > 1) ? $clog2(scanDivider) : 1;
    localparam int SLOT_BITS = $clog2(`DIGIT_COUNT);
    localparam logic [DIV_BITS-1:0]  DIV_LAST  = DIV_BITS'(scanDivider - 1);
    localparam logic [SLOT_BITS-1:0] SLOT_LAST = SLOT_BITS'(`DIGIT_COUNT - 1);

    dispTypesPkg::bcdWord_t  heldDigits;
    logic                    heldOverflow;
    logic [DIV_BITS-1:0]     divCount;
    logic [SLOT_BITS-1:0]    slot;
    dispTypesPkg::bcdDigit_t currentDigit;

    assign bcdIn.ready = 1'b1; // Display never stalls the converter.

    always_ff @(posedge clock) begin
        if (rst) begin
            heldDigits   <= '0;
            heldOverflow <= 1'b0;
        end else if (bcdIn.valid) begin
            heldDigits   <= bcdIn.digits;
            heldOverflow <= bcdIn.overflow;
        end
    end

    // Slot moves on once per divider period.
    always_ff @(posedge clock) begin
        if (rst) begin
            divCount <= '0;
            slot     <= '0;
        end else if (divCount == DIV_LAST) begin
            divCount <= '0;
            slot     <= (slot == SLOT_LAST) ? '0 : slot + 1'b1;
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    assign currentDigit = heldDigits[slot];

    always_comb begin
        an       = '1; // Upper anodes stay dark.
        an[slot] = 1'b0;
    end

    always_comb begin
        if (heldOverflow || currentDigit > 4'd9) begin
            seg = segPatternPkg::SEG_BROKEN;
        end else begin
            seg = segPatternPkg::SEG_DIGIT[currentDigit];
        end
    end

endmodule

//--- hdl/regToSegment.sv
`timescale 1ns/1ns
`include "disp_params.svh"

module regToSegment #(
    parameter int scanDivider = `SCAN_DIV_DEFAULT
) (
    input  logic                    clock,
    input  logic                    rst,
    input  logic [`VALUE_WIDTH-1:0] value,
    input  logic                    valueValid,
    output logic                    valueReady,
    output logic [7:0]              an,
    output logic [6:0]              seg
);

    dispTypesPkg::binValue_t skidValue;
    logic                    skidValid;
    logic                    skidReady;

    bcdIf bcdLink ();

    valueSkid valueSkid_i (
        .clock    (clock),
        .rst      (rst),
        .inValue  (value),
        .inValid  (valueValid),
        .inReady  (valueReady),
        .outValue (skidValue),
        .outValid (skidValid),
        .outReady (skidReady)
    );

    // Sequential converter, busy for one cycle per value bit.
    binToBcd binToBcd_i (
        .clock   (clock),
        .rst     (rst),
        .inValue (skidValue),
        .inValid (skidValid),
        .inReady (skidReady),
        .bcdOut  (bcdLink.source)
    );

    segmentScanner #(
        .scanDivider (scanDivider)
    ) segmentScanner_i (
        .clock (clock),
        .rst   (rst),
        .bcdIn (bcdLink.sink),
        .an    (an),
        .seg   (seg)
    );

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int period = 8
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    // Half period high, half period low.
    always begin
        #(period / 2);
        clock = ~clock;
    end

endmodule

//--- testbench/regToSegment_chk.sv
`timescale 1ns/1ns
`include "disp_params.svh"

module regToSegment_chk (
    input logic                    clock,
    input logic                    rst,
    input logic [7:0]              an,
    input logic [`VALUE_WIDTH-1:0] value,
    input logic                    valueValid,
    input logic                    valueReady,
    input logic                    bcdValid,
    input logic                    bcdReady
);

    upperDark: assert property (@(posedge clock) disable iff (rst) an[7:4] == 4'hF)
        else $error("upper anodes were driven low");

    oneAnode: assert property (@(posedge clock) disable iff (rst) $onehot(~an[3:0]))
        else $error("lower anodes do not have exactly one active digit");

    // Active low, so the zero bit moves one place up.
    anodeOrder: assert property (@(posedge clock) disable iff (rst)
        (an[3:0] != $past(an[3:0])) |-> (an[3:0] == {$past(an[2:0]), $past(an[3])}))
        else $error("anode rotation skipped or reversed a slot");

    inputHeld: assert property (@(posedge clock) disable iff (rst)
        (valueValid && !valueReady) |=> (valueValid && $stable(value)))
        else $error("input value changed while waiting for valueReady");

    // Valid holds until the scanner takes the result, then drops.
    bcdHeld: assert property (@(posedge clock) disable iff (rst)
        bcdValid |=> ($past(bcdReady) ? !bcdValid : bcdValid))
        else $error("converter valid did not follow the scanner handshake");

endmodule

bind regToSegment regToSegment_chk regToSegmentChk_i (
    .clock      (clock),
    .rst        (rst),
    .an         (an),
    .value      (value),
    .valueValid (valueValid),
    .valueReady (valueReady),
    .bcdValid   (bcdLink.valid),
    .bcdReady   (bcdLink.ready)
);

//--- testbench/regToSegment_tb.sv
`timescale 1ns/1ns
`include "disp_params.svh"

module regToSegment_tb;

    localparam int    SCAN_DIV        = 4;
    localparam int    DRIVE_DELAY     = 1;
    localparam int    HANDSHAKE_LIMIT = 100;
    localparam int    POLL_LIMIT      = 200;
    localparam string STIM_FILE       = "testbench/regToSegment_stimulus.txt";

    logic                      clock;
    logic                      rst;
    logic [`VALUE_WIDTH-1:0]   value;
    logic                      valueValid;
    logic                      valueReady;
    logic [7:0]                an;
    logic [6:0]                seg;

    string                     stimNames[$];
    logic [`VALUE_WIDTH-1:0]   stimValues[$];
    logic [4*`DIGIT_COUNT-1:0] stimDigits[$];
    bit                        stimOverflow[$];

    int passCount;
    int failCount;
    bit sawBackPressure;

    clockGen #(.period(8)) clockGen_i (.clock(clock));

    regToSegment #(
        .scanDivider (SCAN_DIV)
    ) regToSegment_i (
        .clock      (clock),
        .rst        (rst),
        .value      (value),
        .valueValid (valueValid),
        .valueReady (valueReady),
        .an         (an),
        .seg        (seg)
    );

    // Broken pattern whenever the value overflowed.
    function automatic logic [6:0] expectedSeg(input logic [3:0] digit, input bit overflow);
        if (overflow) begin
            return segPatternPkg::SEG_BROKEN;
        end
        return segPatternPkg::SEG_DIGIT[digit];
    endfunction

    task automatic loadStimulus();
        int    fd;
        int    fields;
        string line;
        string name;
        int    num;
        int    d3, d2, d1, d0, ovf;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            failCount++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %d %d %d %d %d %d", name, num, d3, d2, d1, d0, ovf);
            if (fields == 7) begin // Comment lines never parse fully.
                stimNames.push_back(name);
                stimValues.push_back(num[`VALUE_WIDTH-1:0]);
                stimDigits.push_back({d3[3:0], d2[3:0], d1[3:0], d0[3:0]});
                stimOverflow.push_back(ovf != 0);
            end
        end
        $fclose(fd);
        if (stimValues.size() == 0) begin
            $display("stimulus file held no usable test lines");
            failCount++;
        end
    endtask

    task automatic alignDrive();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    // Called at drive time, returns at drive time after the accepting edge.
    task automatic sendValue(input logic [`VALUE_WIDTH-1:0] v, input string testName,
                             output bit accepted);
        int waitCycles;
        accepted   = 1'b0;
        waitCycles = 0;
        value      = v;
        valueValid = 1'b1;
        while (!accepted && waitCycles < HANDSHAKE_LIMIT) begin
            @(negedge clock);
            if (valueReady) begin
                accepted = 1'b1; // Ready is registered, so it holds at the next edge.
            end else begin
                sawBackPressure = 1'b1;
            end
            @(posedge clock);
            #DRIVE_DELAY;
            waitCycles++;
        end
        if (!accepted) begin
            $display("timeout in test %s, value %0d was never accepted", testName, v);
        end
    endtask

    task automatic checkDisplay(input string testName, input logic [4*`DIGIT_COUNT-1:0] digits,
                                input bit overflow, output bit ok);
        logic [6:0] want;
        logic [6:0] lastSeg;
        bit         seen;
        bit         matched;
        int         waitCycles;
        ok = 1'b1;
        for (int k = 0; k < `DIGIT_COUNT; k++) begin
            want       = expectedSeg(digits[4*k +: 4], overflow);
            lastSeg    = '1;
            seen       = 1'b0;
            matched    = 1'b0;
            waitCycles = 0;
            while (!matched && waitCycles < POLL_LIMIT) begin
                @(negedge clock);
                if (an[k] == 1'b0) begin
                    seen    = 1'b1;
                    lastSeg = seg;
                    if (seg == want) begin
                        matched = 1'b1;
                    end
                end
                waitCycles++;
            end
            if (!seen) begin
                $display("timeout in test %s, anode %0d never went low", testName, k);
                ok = 1'b0;
            end else if (!matched) begin
                $display("mismatch in test %s digit %0d: expected %b, actual %b",
                         testName, k, want, lastSeg);
                ok = 1'b0;
            end
        end
    endtask

    task automatic recordResult(input string testName, input bit ok);
        if (ok) begin
            passCount++;
            $display("test %s passed", testName);
        end else begin
            failCount++;
            $display("test %s failed", testName);
        end
    endtask

    // All stimulus values back to back, then the last one must be on display.
    task automatic runBurst(input string burstName, input bit reversed);
        bit accepted;
        bit ok;
        bit displayOk;
        int idx;
        int gap;
        int last;
        ok   = 1'b1;
        last = -1;
        gap  = ($urandom % 8) + 1;
        repeat (gap) @(posedge clock);
        #DRIVE_DELAY;
        sawBackPressure = 1'b0;
        for (int i = 0; i < stimValues.size(); i++) begin
            idx = reversed ? stimValues.size() - 1 - i : i;
            sendValue(stimValues[idx], burstName, accepted);
            if (!accepted) begin
                ok = 1'b0;
                break;
            end
            last = idx;
        end
        valueValid = 1'b0;
        if (ok && !sawBackPressure) begin
            $display("valueReady never went low during %s", burstName);
            ok = 1'b0;
        end
        if (ok && last >= 0) begin
            checkDisplay(burstName, stimDigits[last], stimOverflow[last], displayOk);
            ok = displayOk;
        end else begin
            ok = 1'b0;
        end
        recordResult(burstName, ok);
        alignDrive();
    endtask

    initial begin
        bit accepted;
        bit ok;
        void'($urandom(82));
        rst             = 1'b1;
        value           = '0;
        valueValid      = 1'b0;
        passCount       = 0;
        failCount       = 0;
        sawBackPressure = 1'b0;
        loadStimulus();

        repeat (5) @(posedge clock);
        #DRIVE_DELAY;
        rst = 1'b0;

        checkDisplay("resetZero", '0, 1'b0, ok); // Display starts at 0000.
        recordResult("resetZero", ok);
        alignDrive();

        // Last line first, so no value repeats the display before it.
        for (int i = stimValues.size() - 1; i >= 0; i--) begin
            sendValue(stimValues[i], stimNames[i], accepted);
            valueValid = 1'b0;
            ok = accepted;
            if (accepted) begin
                checkDisplay(stimNames[i], stimDigits[i], stimOverflow[i], ok);
            end
            recordResult(stimNames[i], ok);
            alignDrive();
        end

        // Forward first, so each burst ends on a value not already shown.
        runBurst("burstForward", 1'b0);
        runBurst("burstReverse", 1'b1);

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/regToSegment_stimulus.txt
# columns: name value digit3 digit2 digit1 digit0 overflow
# value in decimal, digit3 is the leftmost digit, digits ignored on overflow
zero 0 0 0 0 0 0
one 1 0 0 0 1 0
mixed 1234 1 2 3 4 0
ovfLow 10000 0 0 0 0 1
ninesLow 9 0 0 0 9 0
digitsAll 5678 5 6 7 8 0
ovfMax 65535 0 0 0 0 1
maxDec 9999 9 9 9 9 0
hundreds 305 0 3 0 5 0
powTwo 4096 4 0 9 6 0
mid 8020 8 0 2 0 0

//--- sim.f
+incdir+include
hdl/dispTypesPkg.sv
hdl/segPatternPkg.sv
hdl/bcdIf.sv
hdl/valueSkid.sv
hdl/binToBcd.sv
hdl/segmentScanner.sv
hdl/regToSegment.sv
testbench/clockGen.sv
testbench/regToSegment_chk.sv
testbench/regToSegment_tb.sv
